// File: rv_int_pipe.f
source/rv_isa_pkg.sv
source/rv_core_pkg.sv
source/rv_decode.sv
source/rv_int_reg_file.sv
source/rv_operand_fetch.sv
source/rv_execute.sv
source/rv_int_pipe.sv
bench/tb_clock_gen.sv
bench/rv_int_pipe_checker.sv
bench/rv_int_pipe_tb.sv

// File: build.sh
#!/bin/sh
# compile and run the rv_int_pipe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module rv_int_pipe_tb -Mdir obj_dir -f rv_int_pipe.f

out=$(./obj_dir/Vrv_int_pipe_tb)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***'

// File: bench/rv_int_pipe_tb.sv
// RV32I integer pipeline testbench

`timescale 1ns/1ps

module rv_int_pipe_tb;

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  localparam logic [31:0] SEED = 32'h727bb0e8;
  localparam int IDLE_CYC    = 10;
  localparam int DRAIN_CYC   = 4;    // past the 3 edge latency
  localparam int N_TESTS     = 6;
  localparam int N_PROBE     = 31;
  localparam int N_SEED      = 62;   // lui + addi per register
  localparam int N_RTYPE     = 200;
  localparam int N_ITYPE     = 150;
  localparam int N_ZERO      = 16;   // pairs
  localparam int N_ILL       = 30;   // pairs
  localparam int N_MIX       = 120;
  localparam int MAX_BUBBLES = 3;
  localparam int TOTAL_INSTR = N_PROBE + N_SEED + N_RTYPE + N_ITYPE + 2*N_ZERO + 2*N_ILL + N_MIX;
  localparam int GAP_CYC     = IDLE_CYC + N_TESTS*(DRAIN_CYC+1) + N_MIX*MAX_BUBBLES + 2;
  localparam int MAX_CYCLES  = (TOTAL_INSTR + 3 + 8 + GAP_CYC) * 2;

  logic                  clk;
  logic                  arst_n;
  logic                  instr_valid;
  logic [ILEN-1:0]       instr;
  logic                  wb_valid;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_data;
  logic                  illegal;
  logic                  exp_valid;     // expected record for the checker
  logic                  exp_illegal;
  logic [REG_ADDR_W-1:0] exp_rd;
  logic [XLEN-1:0]       exp_data;
  logic                  test_end;
  int                    test_num;
  logic                  summary;
  int                    err_cnt;
  int                    cycle_cnt = 0;
  logic [31:0]           lcg_state;
  logic [XLEN-1:0]       model_regs [NUM_REGS];  // architectural state, program order
  logic [REG_ADDR_W-1:0] hist [3];               // last three destinations

  tb_clock_gen i_tb_clock_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  rv_int_pipe i_rv_int_pipe (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .wb_valid_o    (wb_valid),
    .wb_rd_o       (wb_rd),
    .wb_data_o     (wb_data),
    .illegal_o     (illegal)
  );

  rv_int_pipe_checker i_rv_int_pipe_checker (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .exp_valid_i   (exp_valid),
    .exp_illegal_i (exp_illegal),
    .exp_rd_i      (exp_rd),
    .exp_data_i    (exp_data),
    .wb_valid_i    (wb_valid),
    .wb_rd_i       (wb_rd),
    .wb_data_i     (wb_data),
    .illegal_i     (illegal),
    .test_end_i    (test_end),
    .test_num_i    (test_num),
    .summary_i     (summary),
    .err_cnt_o     (err_cnt)
  );

  ////////////////////////////////////////
  // random numbers and encoders
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 15);  // fold high bits down
  endfunction

  function automatic logic [REG_ADDR_W-1:0] rand_rd();
    return REG_ADDR_W'(lcg_next() % 31 + 1);  // x1..x31
  endfunction

  function automatic logic [REG_ADDR_W-1:0] pick_src();
    return hist[2'(lcg_next() % 3)];
  endfunction

  function automatic logic [ILEN-1:0] enc_r(input logic [F7_W-1:0] f7,
      input logic [REG_ADDR_W-1:0] rs2, input logic [REG_ADDR_W-1:0] rs1,
      input logic [F3_W-1:0] f3, input logic [REG_ADDR_W-1:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [ILEN-1:0] enc_i(input logic [11:0] imm,
      input logic [REG_ADDR_W-1:0] rs1, input logic [F3_W-1:0] f3,
      input logic [REG_ADDR_W-1:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [ILEN-1:0] enc_u(input logic [19:0] imm,
      input logic [REG_ADDR_W-1:0] rd);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic logic [ILEN-1:0] rand_rtype(input logic [REG_ADDR_W-1:0] rs1,
      input logic [REG_ADDR_W-1:0] rs2, input logic [REG_ADDR_W-1:0] rd);
    logic [31:0]     r;
    logic [F3_W-1:0] f3;
    logic [F7_W-1:0] f7;
    r  = lcg_next();
    f3 = r[2:0];
    f7 = F7_BASE;
    if ((f3 == F3_ADD_SUB || f3 == F3_SR) && r[8]) f7 = F7_ALT;  // sub, sra
    return enc_r(f7, rs2, rs1, f3, rd);
  endfunction

  function automatic logic [ILEN-1:0] rand_itype(input logic [REG_ADDR_W-1:0] rs1,
      input logic [REG_ADDR_W-1:0] rd);
    logic [31:0] r;
    r = lcg_next();
    case (r[3:0])  // imm sign comes from r[31]
      4'd1:        return enc_i(r[31:20], rs1, F3_SLT, rd);
      4'd2:        return enc_i(r[31:20], rs1, F3_SLTU, rd);
      4'd3:        return enc_i(r[31:20], rs1, F3_XOR, rd);
      4'd4:        return enc_i(r[31:20], rs1, F3_OR, rd);
      4'd5:        return enc_i(r[31:20], rs1, F3_AND, rd);
      4'd6:        return enc_i({F7_BASE, r[24:20]}, rs1, F3_SLL, rd);
      4'd7:        return enc_i({F7_BASE, r[24:20]}, rs1, F3_SR, rd);   // srli
      4'd8:        return enc_i({F7_ALT, r[24:20]}, rs1, F3_SR, rd);    // srai
      4'd9, 4'd10: return enc_u(r[31:12], rd);
      default:     return enc_i(r[31:20], rs1, F3_ADD_SUB, rd);
    endcase
  endfunction

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic void model_exec(input logic [ILEN-1:0] ins, output logic ill,
      output logic [REG_ADDR_W-1:0] rd, output logic [XLEN-1:0] val);
    logic [OPC_W-1:0] opc;
    logic [F3_W-1:0]  f3;
    logic [F7_W-1:0]  f7;
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
    logic             imm_form;
    opc      = ins[6:0];
    f3       = ins[14:12];
    f7       = ins[31:25];
    rd       = ins[11:7];
    imm_form = (opc == OPC_OP_IMM);
    a        = model_regs[ins[19:15]];
    b        = imm_form ? {{(XLEN-12){ins[31]}}, ins[31:20]} : model_regs[ins[24:20]];
    val      = '0;
    ill      = 1'b0;
    if (opc == OPC_LUI) begin
      val = {ins[31:12], 12'h000};
    end else if (opc == OPC_OP || imm_form) begin
      case (f3)
        F3_ADD_SUB: val = (!imm_form && f7 == F7_ALT) ? a - b : a + b;
        F3_SLL:     val = a << b[4:0];
        F3_SLT:     val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        F3_SLTU:    val = (a < b) ? 32'd1 : 32'd0;
        F3_XOR:     val = a ^ b;
        F3_SR: begin
          if (f7 == F7_ALT) val = $signed(a) >>> b[4:0];  // sign fill
          else val = a >> b[4:0];
        end
        F3_OR:      val = a | b;
        default:    val = a & b;
      endcase
      // funct7 rules of the base ISA
      if (!imm_form) ill = !(f7 == F7_BASE || (f7 == F7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SR)));
      else if (f3 == F3_SLL) ill = (f7 != F7_BASE);
      else if (f3 == F3_SR) ill = !(f7 == F7_BASE || f7 == F7_ALT);
    end else begin
      ill = 1'b1;  // opcode outside the subset
    end
  endfunction

  ////////////////////////////////////////
  // drivers, called at the falling edge
  ////////////////////////////////////////

  task automatic send_instr(input logic [ILEN-1:0] ins);
    logic                  ill;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       val;
    model_exec(ins, ill, rd, val);
    if (!ill && rd != '0) begin
      model_regs[rd] = val;
      hist[2] = hist[1];
      hist[1] = hist[0];
      hist[0] = rd;
    end
    instr_valid = 1'b1;
    instr       = ins;
    exp_valid   = 1'b1;
    exp_illegal = ill;
    exp_rd      = rd;
    exp_data    = val;
    @(negedge clk);
  endtask

  task automatic send_bubble();
    instr_valid = 1'b0;
    instr       = lcg_next();  // junk must not leak through
    exp_valid   = 1'b0;
    @(negedge clk);
  endtask

  task automatic end_test(input int num);
    repeat (DRAIN_CYC) send_bubble();
    test_num = num;
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    logic [31:0]           r;
    logic [ILEN-1:0]       ins;
    logic [REG_ADDR_W-1:0] rd;
    logic [F3_W-1:0]       f3;
    instr_valid = 1'b0;
    instr       = '0;
    exp_valid   = 1'b0;
    exp_illegal = 1'b0;
    exp_rd      = '0;
    exp_data    = '0;
    test_end    = 1'b0;
    test_num    = 0;
    summary     = 1'b0;
    lcg_state   = SEED;
    for (int n = 0; n < NUM_REGS; n++) model_regs[n] = '0;
    hist[0] = 5'd1;
    hist[1] = 5'd2;
    hist[2] = 5'd3;
    wait (arst_n == 1'b1);
    @(negedge clk);

    // 1: quiet after reset, every register reads zero
    repeat (IDLE_CYC) send_bubble();
    for (int n = 1; n < NUM_REGS; n++) begin
      send_instr(enc_r(F7_BASE, REG_ADDR_W'(n), '0, F3_ADD_SUB, REG_ADDR_W'(n)));
    end
    end_test(1);

    // 2: seed registers, then dependent reg-reg chains
    for (int n = 1; n < NUM_REGS; n++) begin
      r = lcg_next();
      send_instr(enc_u(r[31:12], REG_ADDR_W'(n)));
      send_instr(enc_i(r[11:0], REG_ADDR_W'(n), F3_ADD_SUB, REG_ADDR_W'(n)));
    end
    for (int k = 0; k < N_RTYPE; k++) send_instr(rand_rtype(pick_src(), pick_src(), rand_rd()));
    end_test(2);

    // 3: reg-imm and lui
    for (int k = 0; k < N_ITYPE; k++) send_instr(rand_itype(pick_src(), rand_rd()));
    end_test(3);

    // 4: rd 0 writes, then x0 read while the writer is in flight
    for (int k = 0; k < N_ZERO; k++) begin
      send_instr(rand_itype(pick_src(), '0));
      send_instr(enc_r(F7_BASE, '0, '0, F3_OR, rand_rd()));
    end
    end_test(4);

    // 5: illegal encodings, each followed by a reader of its rd
    for (int k = 0; k < N_ILL; k++) begin
      rd = rand_rd();
      r  = lcg_next();
      f3 = (r[4:2] == F3_ADD_SUB || r[4:2] == F3_SR) ? F3_XOR : r[4:2];
      case (r[1:0])
        2'd0: begin
          ins = lcg_next();
          if (ins[6:0] == OPC_OP || ins[6:0] == OPC_OP_IMM || ins[6:0] == OPC_LUI) begin
            ins[6] = ~ins[6];  // push out of the subset
          end
          ins[11:7] = rd;
        end
        2'd1:    ins = enc_r({r[14:9], 1'b1}, pick_src(), pick_src(), r[4:2], rd);  // odd funct7
        2'd2:    ins = enc_r(F7_ALT, pick_src(), pick_src(), f3, rd);
        default: ins = enc_i({F7_ALT, r[24:20]}, pick_src(), F3_SLL, rd);
      endcase
      send_instr(ins);
      send_instr(enc_r(F7_BASE, '0, rd, F3_ADD_SUB, rand_rd()));
    end
    end_test(5);

    // 6: bubbles between instructions
    for (int k = 0; k < N_MIX; k++) begin
      r = lcg_next();
      repeat (r[1:0]) send_bubble();
      if (r[5]) send_instr(rand_rtype(pick_src(), pick_src(), rand_rd()));
      else send_instr(rand_itype(pick_src(), rand_rd()));
    end
    end_test(6);

    summary = 1'b1;
    @(negedge clk);
    summary = 1'b0;
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: bench/rv_int_pipe_checker.sv
// writeback and illegal checker

`timescale 1ns/1ps

module rv_int_pipe_checker (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              exp_valid_i,    // instruction sampled this edge
  input  logic                              exp_illegal_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] exp_rd_i,
  input  logic [rv_core_pkg::XLEN-1:0]      exp_data_i,
  input  logic                              wb_valid_i,     // dut outputs
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_rd_i,
  input  logic [rv_core_pkg::XLEN-1:0]      wb_data_i,
  input  logic                              illegal_i,
  input  logic                              test_end_i,     // after the drain
  input  int                                test_num_i,
  input  logic                              summary_i,
  output int                                err_cnt_o
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  localparam int LATENCY = 3;  // edges from sample to visible output

  typedef struct packed {
    logic                  ill;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
    logic [31:0]           due;   // cycle the output must show
  } exp_t;

  exp_t        exp_q[$];
  exp_t        rec;
  logic [31:0] cyc = '0;
  int          err_cnt = 0;
  int          err_base = 0;   // errors before the current test
  int          n_checked = 0;
  int          n_tests = 0;
  int          n_failed = 0;

  assign err_cnt_o = err_cnt;

  ////////////////////////////////////////
  // compare, outputs are pre-edge values
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    if (arst_n_i) begin
      if (wb_valid_i && illegal_i) begin
        $display("wb_valid_o and illegal_o both high in cycle %0d", cyc);
        err_cnt++;
      end
      if (wb_valid_i || illegal_i) begin
        n_checked++;
        if (exp_q.size() == 0) begin
          $display("unexpected output in cycle %0d with nothing pending", cyc);
          err_cnt++;
        end else begin
          rec = exp_q.pop_front();
          if (rec.due != cyc) begin
            $display("output in cycle %0d, expected in cycle %0d", cyc, rec.due);
            err_cnt++;
          end
          if (rec.ill) begin
            if (!illegal_i) begin
              $display("write to x%0d where an illegal instruction was expected", wb_rd_i);
              err_cnt++;
            end
          end else if (!wb_valid_i) begin
            $display("illegal_o pulsed where a write to x%0d was expected", rec.rd);
            err_cnt++;
          end else begin
            if (wb_rd_i != rec.rd) begin
              $display("FAIL wb_rd_o: got %02h, expected %02h", wb_rd_i, rec.rd);
              err_cnt++;
            end
            if (wb_data_i != rec.data) begin
              $display("FAIL wb_data_o: got %08h, expected %08h (x%0d)",
                       wb_data_i, rec.data, rec.rd);
              err_cnt++;
            end
          end
        end
      end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
        rec = exp_q.pop_front();  // nothing came out in time
        $display("no output for the instruction sampled in cycle %0d", rec.due - LATENCY);
        err_cnt++;
      end
      if (exp_valid_i) begin
        rec.ill  = exp_illegal_i;
        rec.rd   = exp_rd_i;
        rec.data = exp_data_i;
        rec.due  = cyc + LATENCY;
        exp_q.push_back(rec);
      end
      if (test_end_i) begin
        if (exp_q.size() != 0) begin
          $display("%0d outputs still outstanding after the drain", exp_q.size());
          err_cnt++;
          exp_q.delete();
        end
        n_tests++;
        if (err_cnt != err_base) n_failed++;
        $display("test %0d done: %0d errors", test_num_i, err_cnt - err_base);
        err_base = err_cnt;
      end
      if (summary_i) begin
        $display("%0d tests, %0d failed, %0d outputs checked, %0d errors",
                 n_tests, n_failed, n_checked, err_cnt);
      end
      cyc = cyc + 1;
    end
  end

endmodule

// File: bench/tb_clock_gen.sv
// bench clock and reset

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,     // 100 ns period
  output logic arst_n_o   // low for the first cycles
);

  localparam int HALF_NS    = 50;
  localparam int RST_CYCLES = 8;

  initial begin
    clk_o = 1'b0;
    forever #HALF_NS clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);  // release away from the active edge
    arst_n_o = 1'b1;
  end

endmodule

// File: source/rv_int_pipe.sv
// RV32I integer pipeline top

`timescale 1ns/1ps

module rv_int_pipe (
  input  logic                              clk_i,          // core clock
  input  logic                              arst_n_i,       // async reset, active low
  input  logic                              instr_valid_i,  // one instruction per cycle
  input  logic [rv_isa_pkg::ILEN-1:0]       instr_i,
  output logic                              wb_valid_o,     // register write reported
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [rv_core_pkg::XLEN-1:0]      wb_data_o,
  output logic                              illegal_o       // rejected instruction
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  ////////////////////////////////////////
  // stage wires
  ////////////////////////////////////////

  logic                  dec_valid;
  logic                  dec_illegal;
  logic [REG_ADDR_W-1:0] dec_rd;
  logic [REG_ADDR_W-1:0] dec_rs1;
  logic [REG_ADDR_W-1:0] dec_rs2;
  logic [XLEN-1:0]       dec_imm;
  logic                  dec_use_imm;
  alu_op_e               dec_alu_op;
  logic                  opf_valid;
  logic                  opf_illegal;
  logic [REG_ADDR_W-1:0] opf_rd;
  logic [XLEN-1:0]       opf_a;
  logic [XLEN-1:0]       opf_b;
  alu_op_e               opf_alu_op;
  logic                  ex_valid;    // bypass from execute
  logic [REG_ADDR_W-1:0] ex_rd;
  logic [XLEN-1:0]       ex_result;

  rv_decode i_rv_decode (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .dec_valid_o   (dec_valid),
    .dec_illegal_o (dec_illegal),
    .dec_rd_o      (dec_rd),
    .dec_rs1_o     (dec_rs1),
    .dec_rs2_o     (dec_rs2),
    .dec_imm_o     (dec_imm),
    .dec_use_imm_o (dec_use_imm),
    .dec_alu_op_o  (dec_alu_op)
  );

  rv_operand_fetch i_rv_operand_fetch (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .dec_valid_i   (dec_valid),
    .dec_illegal_i (dec_illegal),
    .dec_rd_i      (dec_rd),
    .dec_rs1_i     (dec_rs1),
    .dec_rs2_i     (dec_rs2),
    .dec_imm_i     (dec_imm),
    .dec_use_imm_i (dec_use_imm),
    .dec_alu_op_i  (dec_alu_op),
    .ex_valid_i    (ex_valid),
    .ex_rd_i       (ex_rd),
    .ex_result_i   (ex_result),
    .wb_valid_i    (wb_valid_o),  // writeback also feeds regfile
    .wb_rd_i       (wb_rd_o),
    .wb_data_i     (wb_data_o),
    .opf_valid_o   (opf_valid),
    .opf_illegal_o (opf_illegal),
    .opf_rd_o      (opf_rd),
    .opf_a_o       (opf_a),
    .opf_b_o       (opf_b),
    .opf_alu_op_o  (opf_alu_op)
  );

  rv_execute i_rv_execute (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .opf_valid_i   (opf_valid),
    .opf_illegal_i (opf_illegal),
    .opf_rd_i      (opf_rd),
    .opf_a_i       (opf_a),
    .opf_b_i       (opf_b),
    .opf_alu_op_i  (opf_alu_op),
    .ex_valid_o    (ex_valid),
    .ex_rd_o       (ex_rd),
    .ex_result_o   (ex_result),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o),
    .illegal_o     (illegal_o)
  );

endmodule

// File: source/rv_execute.sv
// execute stage and writeback register

`timescale 1ns/1ps

module rv_execute (
  input  logic                              clk_i,          // core clock
  input  logic                              arst_n_i,       // async reset, active low
  input  logic                              opf_valid_i,    // from operand fetch
  input  logic                              opf_illegal_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] opf_rd_i,
  input  logic [rv_core_pkg::XLEN-1:0]      opf_a_i,
  input  logic [rv_core_pkg::XLEN-1:0]      opf_b_i,
  input  rv_core_pkg::alu_op_e              opf_alu_op_i,
  output logic                              ex_valid_o,     // bypass source, comb
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] ex_rd_o,
  output logic [rv_core_pkg::XLEN-1:0]      ex_result_o,
  output logic                              wb_valid_o,     // writeback register
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [rv_core_pkg::XLEN-1:0]      wb_data_o,
  output logic                              illegal_o       // one-cycle pulse
);

  import rv_core_pkg::*;

  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    alu_res;

  assign shamt = opf_b_i[SHAMT_W-1:0];  // rv32 ignores upper bits

  ////////////////////////////////////////
  // alu
  ////////////////////////////////////////

  always_comb begin
    case (opf_alu_op_i)
      ALU_ADD:    alu_res = opf_a_i + opf_b_i;
      ALU_SUB:    alu_res = opf_a_i - opf_b_i;
      ALU_AND:    alu_res = opf_a_i & opf_b_i;
      ALU_OR:     alu_res = opf_a_i | opf_b_i;
      ALU_XOR:    alu_res = opf_a_i ^ opf_b_i;
      ALU_SLL:    alu_res = opf_a_i << shamt;
      ALU_SRL:    alu_res = opf_a_i >> shamt;
      ALU_SRA:    alu_res = $unsigned($signed(opf_a_i) >>> shamt);
      ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(opf_a_i) < $signed(opf_b_i)};
      ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, opf_a_i < opf_b_i};
      ALU_PASS_B: alu_res = opf_b_i;  // lui
      default:    alu_res = '0;       // unused codes
    endcase
  end

  assign ex_valid_o  = opf_valid_i & ~opf_illegal_i;  // illegal never writes
  assign ex_rd_o     = opf_rd_i;
  assign ex_result_o = alu_res;

  ////////////////////////////////////////
  // writeback register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_valid_o <= 1'b0;
      wb_rd_o    <= '0;
      wb_data_o  <= '0;
      illegal_o  <= 1'b0;
    end else begin
      wb_valid_o <= ex_valid_o;
      illegal_o  <= opf_valid_i & opf_illegal_i;
      if (ex_valid_o) begin  // hold last result across bubbles
        wb_rd_o   <= opf_rd_i;
        wb_data_o <= alu_res;
      end
    end
  end

endmodule

// File: source/rv_operand_fetch.sv
// operand fetch stage with bypass

`timescale 1ns/1ps

module rv_operand_fetch (
  input  logic                              clk_i,          // core clock
  input  logic                              arst_n_i,       // async reset, active low
  input  logic                              dec_valid_i,    // from decode
  input  logic                              dec_illegal_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] dec_rd_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] dec_rs1_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] dec_rs2_i,
  input  logic [rv_core_pkg::XLEN-1:0]      dec_imm_i,
  input  logic                              dec_use_imm_i,
  input  rv_core_pkg::alu_op_e              dec_alu_op_i,
  input  logic                              ex_valid_i,     // legal writer in execute
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] ex_rd_i,
  input  logic [rv_core_pkg::XLEN-1:0]      ex_result_i,    // unregistered alu out
  input  logic                              wb_valid_i,     // writer being retired
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_rd_i,
  input  logic [rv_core_pkg::XLEN-1:0]      wb_data_i,
  output logic                              opf_valid_o,    // to execute
  output logic                              opf_illegal_o,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] opf_rd_o,
  output logic [rv_core_pkg::XLEN-1:0]      opf_a_o,
  output logic [rv_core_pkg::XLEN-1:0]      opf_b_o,        // imm already muxed in
  output rv_core_pkg::alu_op_e              opf_alu_op_o
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic [XLEN-1:0] rf_rs1_data;
  logic [XLEN-1:0] rf_rs2_data;
  logic [XLEN-1:0] opnd_a;
  logic [XLEN-1:0] opnd_b;

  rv_int_reg_file i_rv_int_reg_file (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .wr_en_i    (wb_valid_i),
    .wr_addr_i  (wb_rd_i),
    .wr_data_i  (wb_data_i),
    .rs1_addr_i (dec_rs1_i),
    .rs2_addr_i (dec_rs2_i),
    .rs1_data_o (rf_rs1_data),
    .rs2_data_o (rf_rs2_data)
  );

  ////////////////////////////////////////
  // bypass, youngest writer wins
  ////////////////////////////////////////

  function automatic logic [XLEN-1:0] bypass(input logic [REG_ADDR_W-1:0] rs,
                                             input logic [XLEN-1:0]       rf_val);
    logic [XLEN-1:0] val;
    val = rf_val;
    if (rs != '0) begin  // x0 never forwarded
      if (ex_valid_i && ex_rd_i == rs) val = ex_result_i;
      else if (wb_valid_i && wb_rd_i == rs) val = wb_data_i;
    end
    return val;
  endfunction

  always_comb begin
    opnd_a = bypass(dec_rs1_i, rf_rs1_data);
    opnd_b = dec_use_imm_i ? dec_imm_i : bypass(dec_rs2_i, rf_rs2_data);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      opf_valid_o   <= 1'b0;
      opf_illegal_o <= 1'b0;
    end else begin
      opf_valid_o   <= dec_valid_i;
      opf_illegal_o <= dec_illegal_i;
    end
  end

  always_ff @(posedge clk_i) begin
    opf_rd_o     <= dec_rd_i;
    opf_a_o      <= opnd_a;
    opf_b_o      <= opnd_b;
    opf_alu_op_o <= dec_alu_op_i;
  end

endmodule

// File: source/rv_int_reg_file.sv
// integer register file

`timescale 1ns/1ps

module rv_int_reg_file (
  input  logic                              clk_i,       // core clock
  input  logic                              arst_n_i,    // async reset, active low
  input  logic                              wr_en_i,     // write strobe
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] wr_addr_i,   // destination index
  input  logic [rv_core_pkg::XLEN-1:0]      wr_data_i,   // write value
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr_i,  // read port 1 index
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr_i,  // read port 2 index
  output logic [rv_core_pkg::XLEN-1:0]      rs1_data_o,  // read port 1 data
  output logic [rv_core_pkg::XLEN-1:0]      rs2_data_o   // read port 2 data
);

  import rv_core_pkg::*;

  logic [NUM_REGS-1:0] wr_dec;                 // one-hot write enable
  logic [XLEN-1:0]     regs [1:NUM_REGS-1];    // x1..x31, no storage for x0

  always_comb begin
    wr_dec            = '0;
    wr_dec[wr_addr_i] = wr_en_i;
  end

  ////////////////////////////////////////
  // x1..x31
  ////////////////////////////////////////

  for (genvar i = 1; i < NUM_REGS; i++) begin : g_reg
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        regs[i] <= '0;
      end else if (wr_dec[i]) begin
        regs[i] <= wr_data_i;
      end
    end
  end

  // read muxes, no clock, x0 hardwired
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: source/rv_decode.sv
// decode stage

`timescale 1ns/1ps

module rv_decode (
  input  logic                               clk_i,          // core clock
  input  logic                               arst_n_i,       // async reset, active low
  input  logic                               instr_valid_i,  // instruction strobe
  input  logic [rv_isa_pkg::ILEN-1:0]        instr_i,        // raw instruction word
  output logic                               dec_valid_o,    // slot holds an instruction
  output logic                               dec_illegal_o,  // unsupported encoding
  output logic [rv_isa_pkg::REG_ADDR_W-1:0]  dec_rd_o,       // destination
  output logic [rv_isa_pkg::REG_ADDR_W-1:0]  dec_rs1_o,      // source 1
  output logic [rv_isa_pkg::REG_ADDR_W-1:0]  dec_rs2_o,      // source 2
  output logic [rv_core_pkg::XLEN-1:0]       dec_imm_o,      // i or u immediate
  output logic                               dec_use_imm_o,  // b comes from imm
  output rv_core_pkg::alu_op_e               dec_alu_op_o    // alu function
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  ////////////////////////////////////////
  // field split
  ////////////////////////////////////////

  logic [OPC_W-1:0]      opcode;
  logic [F3_W-1:0]       funct3;
  logic [F7_W-1:0]       funct7;
  logic [XLEN-1:0]       imm_i;    // sign-extended 12 bit
  logic [XLEN-1:0]       imm_u;    // upper 20, already shifted
  logic [XLEN-1:0]       imm;
  logic [REG_ADDR_W-1:0] rs1;
  logic                  use_imm;
  logic                  ill;
  alu_op_e               alu_op;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign imm_i  = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_u  = {instr_i[31:12], 12'b0};

  ////////////////////////////////////////
  // op select
  ////////////////////////////////////////

  always_comb begin
    alu_op  = ALU_ADD;
    use_imm = 1'b0;
    imm     = imm_i;
    rs1     = instr_i[19:15];
    ill     = 1'b0;
    case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        use_imm = (opcode == OPC_OP_IMM);
        case (funct3)
          F3_ADD_SUB: alu_op = (opcode == OPC_OP && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
          F3_SLL:     alu_op = ALU_SLL;
          F3_SLT:     alu_op = ALU_SLT;
          F3_SLTU:    alu_op = ALU_SLTU;
          F3_XOR:     alu_op = ALU_XOR;
          F3_SR:      alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
          F3_OR:      alu_op = ALU_OR;
          default:    alu_op = ALU_AND;  // F3_AND, last of eight
        endcase
        // funct7 only matters for reg-reg and the shift-imm forms
        if (opcode == OPC_OP || funct3 == F3_SLL || funct3 == F3_SR) begin
          ill = !(funct7 == F7_BASE ||
                  (funct7 == F7_ALT && (funct3 == F3_SR ||
                   (funct3 == F3_ADD_SUB && opcode == OPC_OP))));
        end
      end
      OPC_LUI: begin
        alu_op  = ALU_PASS_B;
        use_imm = 1'b1;
        imm     = imm_u;
        rs1     = '0;  // keeps the bypass quiet
      end
      default: ill = 1'b1;  // anything outside the subset
    endcase
  end

  ////////////////////////////////////////
  // stage register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_valid_o   <= 1'b0;
      dec_illegal_o <= 1'b0;
    end else begin
      dec_valid_o   <= instr_valid_i;
      dec_illegal_o <= instr_valid_i & ill;  // bubbles are never illegal
    end
  end

  always_ff @(posedge clk_i) begin
    dec_rd_o      <= instr_i[11:7];
    dec_rs1_o     <= rs1;
    dec_rs2_o     <= instr_i[24:20];  // imm bits on i-type, unused there
    dec_imm_o     <= imm;
    dec_use_imm_o <= use_imm;
    dec_alu_op_o  <= alu_op;
  end

endmodule

// File: source/rv_core_pkg.sv
// integer datapath definitions

package rv_core_pkg;

  ////////////////////////////////////////
  // datapath sizes
  ////////////////////////////////////////

  localparam int XLEN     = 32;  // register width
  localparam int NUM_REGS = 32;  // x0..x31
  localparam int SHAMT_W  = 5;   // shift amount bits of operand b

  ////////////////////////////////////////
  // alu operations
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLL    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,   // arithmetic, sign fill
    ALU_SLT    = 4'd8,   // signed compare
    ALU_SLTU   = 4'd9,   // unsigned compare
    ALU_PASS_B = 4'd10   // lui, b goes straight through
  } alu_op_e;

endpackage

// File: source/rv_isa_pkg.sv
// RV32I instruction encoding

package rv_isa_pkg;

  ////////////////////////////////////////
  // field widths
  ////////////////////////////////////////

  localparam int ILEN       = 32;  // instruction word
  localparam int REG_ADDR_W = 5;   // rs1, rs2, rd index
  localparam int OPC_W      = 7;   // major opcode
  localparam int F3_W       = 3;   // funct3
  localparam int F7_W       = 7;   // funct7

  ////////////////////////////////////////
  // major opcodes
  ////////////////////////////////////////

  localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;  // reg-reg alu
  localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;  // reg-imm alu
  localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;  // load upper imm

  ////////////////////////////////////////
  // funct3 / funct7
  ////////////////////////////////////////

  localparam logic [F3_W-1:0] F3_ADD_SUB = 3'b000;
  localparam logic [F3_W-1:0] F3_SLL     = 3'b001;
  localparam logic [F3_W-1:0] F3_SLT     = 3'b010;
  localparam logic [F3_W-1:0] F3_SLTU    = 3'b011;
  localparam logic [F3_W-1:0] F3_XOR     = 3'b100;
  localparam logic [F3_W-1:0] F3_SR      = 3'b101;  // srl / sra
  localparam logic [F3_W-1:0] F3_OR      = 3'b110;
  localparam logic [F3_W-1:0] F3_AND     = 3'b111;

  localparam logic [F7_W-1:0] F7_BASE = 7'b0000000;  // add, srl
  localparam logic [F7_W-1:0] F7_ALT  = 7'b0100000;  // sub, sra

endpackage
